// ==== flist.f ====
hw/elink_code_pkg.sv
hw/elink_frame_pkg.sv
hw/elink_word_if.sv
hw/word_fifo.sv
hw/packet_gen.sv
hw/elink_tx.sv
hw/elink_rx.sv
hw/elink_loop_top.sv
dv/tb_elink_loop.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       = tb_elink_loop
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "^Simulation passed$$" $(LOG); then \
		echo "run passed"; \
	else \
		echo "run failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_elink_loop.sv ====
`timescale 1ns/10ps
module tb_elink_loop;

  localparam int wait_limit = 4000;    // cycles allowed for any single wait
  localparam int stall_cycles = 60;    // about 12 words at one word per 5 clocks
  localparam int quiet_cycles = 300;

  logic                                clk = 1'b0;
  logic                                rst_n;
  logic                                loop_en;
  logic [elink_frame_pkg::len_w-1:0]   packet_len;
  logic                                done;
  logic [1:0]                          elink_tx_data;
  logic [1:0]                          elink_rx_data;
  logic [elink_frame_pkg::byte_w-1:0]  rx_data;
  logic [elink_frame_pkg::delim_w-1:0] rx_delim;
  logic                                rx_avail;
  logic                                rx_take;
  logic                                overflow;

  logic [5:0] loop_chain = '0;         // three pair delay on the link
  logic [elink_code_pkg::sym_w-1:0] tx_sym;  // first symbol seen on the link
  integer     seed;
  logic       stall;
  logic       gen_busy = 1'b0;         // generator inside a packet
  int         len_q [$];               // lengths in packet start order
  int         cur_len = 0;
  int         pos = 0;                 // word index inside the current packet
  int         eop_count = 0;
  int         done_count = 0;

  always #20 clk = ~clk;

  assign elink_rx_data = loop_chain[5:4];

  always @(negedge clk)
    loop_chain <= {loop_chain[3:0], elink_tx_data};

  elink_loop_top uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .loop_en       (loop_en),
    .packet_len    (packet_len),
    .done          (done),
    .elink_tx_data (elink_tx_data),
    .elink_rx_data (elink_rx_data),
    .rx_data       (rx_data),
    .rx_delim      (rx_delim),
    .rx_avail      (rx_avail),
    .rx_take       (rx_take),
    .overflow      (overflow)
  );

  // sop, then bytes 0, 1, 2 and so on, then eop
  function automatic logic [9:0] expected_word(input int idx, input int len);
    if (idx == 0)
      return {elink_frame_pkg::delim_sop, 8'h00};
    else if (idx <= len)
      return {elink_frame_pkg::delim_data, 8'(idx - 1)};
    else
      return {elink_frame_pkg::delim_eop, 8'h00};
  endfunction

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic pick_length();
    logic [31:0] draw;
    draw = 1 + ({$random(seed)} % 40);
    packet_len = draw[elink_frame_pkg::len_w-1:0];
  endtask

  task automatic next_cycle();
    @(negedge clk);
    if (stall)
      rx_take = 1'b0;
    else
      rx_take = ({$random(seed)} % 4) != 0;   // host takes about 3 of 4 cycles
    if (({$random(seed)} % 64) == 0)
      pick_length();                          // may land in the middle of a packet
  endtask

  task automatic wait_packets(input int target);
    int cycles;
    cycles = 0;
    while (eop_count < target)
    begin
      next_cycle();
      cycles++;
      if (cycles > wait_limit)
        stop_with_error($sformatf("timeout: packet %0d never completed at the rx ports",
                                  target));
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (gen_busy || len_q.size() != 0 || pos != 0)
    begin
      next_cycle();
      cycles++;
      if (cycles > wait_limit)
        stop_with_error("timeout: the packet in progress never ended after loop_en fell");
    end
  endtask

  // generator bookkeeping and comparison of every word the host accepts
  always @(posedge clk)
  begin
    logic [9:0] exp_word;
    if (rst_n)
    begin
      if (done)
        done_count++;
      if (!gen_busy || done)
      begin
        gen_busy = loop_en;                   // loop_en and packet_len sampled at start
        if (loop_en)
          len_q.push_back(int'(packet_len));
      end
      if (rx_avail && rx_take)
      begin
        if (pos == 0)
        begin
          assert (len_q.size() != 0)
          else
            stop_with_error("a word reached the rx ports with no packet started");
          cur_len = len_q.pop_front();
        end
        exp_word = expected_word(pos, cur_len);
        assert ({rx_delim, rx_data} == exp_word)
        else
          stop_with_error($sformatf(
            "MISMATCH at time %0t: packet %0d word %0d got %0d/%02h, expected %0d/%02h",
            $time, eop_count, pos, rx_delim, rx_data, exp_word[9:8], exp_word[7:0]));
        if (pos == cur_len + 1)
        begin
          pos = 0;
          eop_count++;
        end
        else
          pos++;
      end
      assert (!overflow)
      else
        stop_with_error("overflow went high although the rx fifo was never overrun");
    end
  end

  initial
  begin
    seed = 32'hfeba_b975;
    rst_n = 1'b0;
    loop_en = 1'b0;
    packet_len = '0;
    rx_take = 1'b0;
    stall = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    tx_sym = '0;
    for (int i = 0; i < elink_frame_pkg::slots_per_sym; i++)
    begin
      tx_sym = {tx_sym[elink_code_pkg::sym_w-3:0], elink_tx_data};  // msb pair comes first
      @(negedge clk);
      assert (!rx_avail && !done && !overflow)
      else
        stop_with_error("rx_avail, done or overflow was not low after reset");
    end
    assert (tx_sym == elink_code_pkg::comma_n)
    else
      stop_with_error($sformatf("MISMATCH at time %0t: first tx symbol %b, expected %b",
                                $time, tx_sym, elink_code_pkg::comma_n));

    // receiver aligns on idle commas and must stay silent
    rx_take = 1'b1;
    for (int i = 0; i < 100; i++)
    begin
      @(negedge clk);
      assert (!rx_avail && !done)
      else
        stop_with_error("a word or done pulse appeared while the generator was idle");
    end

    pick_length();
    loop_en = 1'b1;
    wait_packets(4);

    stall = 1'b1;                            // host stops reading
    for (int i = 0; i < stall_cycles; i++)
      next_cycle();
    assert (rx_avail)
    else
      stop_with_error("no word was held in the rx fifo during the host stall");
    stall = 1'b0;
    wait_packets(8);

    loop_en = 1'b0;
    wait_drain();
    for (int i = 0; i < quiet_cycles; i++)
      next_cycle();                          // any late sop fails in the checker

    assert (done_count == eop_count)
    else
      stop_with_error($sformatf("MISMATCH at time %0t: %0d done pulses but %0d eop words",
                                $time, done_count, eop_count));
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== hw/elink_loop_top.sv ====
`timescale 1ns/10ps
module elink_loop_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                loop_en,
  input  logic [elink_frame_pkg::len_w-1:0]   packet_len,
  output logic                                done,
  output logic [1:0]                          elink_tx_data,
  input  logic [1:0]                          elink_rx_data,
  output logic [elink_frame_pkg::byte_w-1:0]  rx_data,
  output logic [elink_frame_pkg::delim_w-1:0] rx_delim,
  output logic                                rx_avail,
  input  logic                                rx_take,
  output logic                                overflow
);

  elink_word_if gen_if ();    // generator into tx fifo
  elink_word_if tx_if ();     // tx fifo into encoder
  elink_word_if rx_if ();     // decoder into rx fifo
  elink_word_if host_if ();   // rx fifo out to the host ports

  packet_gen gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .loop_en    (loop_en),
    .packet_len (packet_len),
    .out        (gen_if),
    .done       (done)
  );

  word_fifo tx_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (gen_if),
    .pop   (tx_if)
  );

  elink_tx tx (
    .clk    (clk),
    .rst_n  (rst_n),
    .in     (tx_if),
    .serial (elink_tx_data)
  );

  elink_rx rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .serial   (elink_rx_data),
    .out      (rx_if),
    .overflow (overflow)
  );

  word_fifo rx_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (rx_if),
    .pop   (host_if)
  );

  assign rx_data = host_if.data;
  assign rx_delim = host_if.delim;
  assign rx_avail = host_if.avail;
  assign host_if.take = rx_take;

endmodule

// ==== hw/elink_rx.sv ====
`timescale 1ns/10ps
module elink_rx (
  input  logic           clk,
  input  logic           rst_n,
  input  logic [1:0]     serial,
  elink_word_if.producer out,
  output logic           overflow
);

  logic [19:0]                         hist;       // newest pair at the lsbs
  logic                                aligned;
  logic [2:0]                          off;        // locked pair offset
  logic [2:0]                          slot;
  logic                                last_slot;
  logic                                hit;
  logic [2:0]                          hit_off;
  logic [elink_code_pkg::sym_w-1:0]    sym;
  logic [8:0]                          dec;        // {k, byte}
  logic [elink_frame_pkg::delim_w-1:0] dec_delim;
  logic                                keep;
  logic                                word_avail;
  logic [elink_frame_pkg::byte_w-1:0]  word_data;
  logic [elink_frame_pkg::delim_w-1:0] word_delim;

  assign last_slot = (slot == 3'(elink_frame_pkg::slots_per_sym - 1));
  assign sym = hist[{off, 1'b0} +: elink_code_pkg::sym_w];
  assign dec = elink_code_pkg::decode_8b10b(sym);

  // comma search over every even offset, lowest offset wins
  always_comb
  begin
    hit = 1'b0;
    hit_off = '0;
    for (int i = ($bits(hist) - elink_code_pkg::sym_w) / 2; i >= 0; i--)
    begin
      if (hist[2*i +: elink_code_pkg::sym_w] == elink_code_pkg::comma_n ||
          hist[2*i +: elink_code_pkg::sym_w] == elink_code_pkg::comma_p)
      begin
        hit = 1'b1;
        hit_off = 3'(i);
      end
    end
  end

  // k characters back to delimiters
  always_comb
  begin
    keep = 1'b1;
    dec_delim = elink_frame_pkg::delim_data;
    if (dec[8])
    begin
      case (dec[7:0])
        elink_code_pkg::k28_1: dec_delim = elink_frame_pkg::delim_sop;
        elink_code_pkg::k28_6: dec_delim = elink_frame_pkg::delim_eop;
        default:
        begin
          dec_delim = elink_frame_pkg::delim_comma;
          keep = 1'b0;                                    // idle symbol
        end
      endcase
    end
  end

  assign out.avail = word_avail;
  assign out.data = word_data;
  assign out.delim = word_delim;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      hist <= '0;
      aligned <= 1'b0;
      off <= '0;
      slot <= '0;
      word_avail <= 1'b0;
      overflow <= 1'b0;
    end
    else
    begin
      hist <= {hist[$bits(hist)-3:0], serial};
      if (!aligned)
      begin
        if (hit)
        begin
          aligned <= 1'b1;
          off <= hit_off;
          slot <= '0;                                     // next symbol in 5 clocks
        end
      end
      else if (last_slot)
        slot <= '0;
      else
        slot <= slot + 1'b1;
      word_avail <= aligned && last_slot && keep;         // single cycle push
      if (word_avail && !out.take)
        overflow <= 1'b1;                                 // sticky, word is lost
    end
  end

  always_ff @(posedge clk)
  begin
    if (aligned && last_slot)
    begin
      word_data <= dec[8] ? '0 : dec[7:0];
      word_delim <= dec_delim;
    end
  end

endmodule

// ==== hw/elink_tx.sv ====
`timescale 1ns/10ps
module elink_tx (
  input  logic           clk,
  input  logic           rst_n,
  elink_word_if.consumer in,
  output logic [1:0]     serial
);

  logic [2:0]                         slot;
  logic [elink_code_pkg::sym_w-1:0]   shreg;
  logic                               rd;       // running disparity, high is positive
  logic [elink_frame_pkg::byte_w-1:0] tx_char;
  logic                               k;
  logic [elink_code_pkg::sym_w:0]     enc;
  logic                               last_slot;

  assign last_slot = (slot == 3'(elink_frame_pkg::slots_per_sym - 1));
  assign in.take = last_slot;                   // one word per symbol period
  assign serial = shreg[elink_code_pkg::sym_w-1 -: 2];

  // comma fill when the fifo is empty
  always_comb
  begin
    k = 1'b1;
    tx_char = elink_code_pkg::k28_5;
    if (in.avail)
    begin
      case (in.delim)
        elink_frame_pkg::delim_data:
        begin
          k = 1'b0;
          tx_char = in.data;
        end
        elink_frame_pkg::delim_sop: tx_char = elink_code_pkg::k28_1;
        elink_frame_pkg::delim_eop: tx_char = elink_code_pkg::k28_6;
        default: tx_char = elink_code_pkg::k28_5;
      endcase
    end
  end

  assign enc = elink_code_pkg::encode_8b10b(tx_char, k, rd);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      slot <= '0;
      shreg <= elink_code_pkg::comma_n;
      rd <= 1'b1;                               // comma_n leaves rd positive
    end
    else if (last_slot)
    begin
      slot <= '0;
      shreg <= enc[elink_code_pkg::sym_w-1:0];
      rd <= enc[elink_code_pkg::sym_w];
    end
    else
    begin
      slot <= slot + 1'b1;
      shreg <= {shreg[elink_code_pkg::sym_w-3:0], 2'b00};  // msb pair first
    end
  end

endmodule

// ==== hw/packet_gen.sv ====
`timescale 1ns/10ps
module packet_gen (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              loop_en,
  input  logic [elink_frame_pkg::len_w-1:0] packet_len,
  elink_word_if.producer                    out,
  output logic                              done
);

  // fsm state is the delimiter of the word on offer, active low means idle
  logic                                active;
  logic [elink_frame_pkg::delim_w-1:0] phase;
  logic [elink_frame_pkg::len_w-1:0]   len_q;
  logic [elink_frame_pkg::len_w-1:0]   cnt;    // payload index
  logic                                xfer;
  logic                                start;

  assign xfer = active && out.take;
  assign done = xfer && (phase == elink_frame_pkg::delim_eop);
  assign start = !active || done;                  // new packet may begin

  assign out.avail = active;
  assign out.delim = phase;
  assign out.data = (phase == elink_frame_pkg::delim_data) ? cnt[elink_frame_pkg::byte_w-1:0] : '0;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      active <= 1'b0;
      phase <= elink_frame_pkg::delim_sop;
      len_q <= '0;
      cnt <= '0;
    end
    else if (start)
    begin
      active <= loop_en;                           // stops after eop when low
      phase <= elink_frame_pkg::delim_sop;
      len_q <= packet_len;
      cnt <= '0;
    end
    else if (xfer)
    begin
      case (phase)
        elink_frame_pkg::delim_sop:
        begin
          if (len_q == '0)
            phase <= elink_frame_pkg::delim_eop;   // empty packet
          else
            phase <= elink_frame_pkg::delim_data;
        end
        default:
        begin
          cnt <= cnt + 1'b1;
          if (cnt == len_q - 1'b1)
            phase <= elink_frame_pkg::delim_eop;
        end
      endcase
    end
  end

endmodule

// ==== hw/word_fifo.sv ====
`timescale 1ns/10ps
module word_fifo (
  input  logic           clk,
  input  logic           rst_n,
  elink_word_if.consumer push,
  elink_word_if.producer pop
);

  logic [elink_frame_pkg::delim_w+elink_frame_pkg::byte_w-1:0] mem [elink_frame_pkg::fifo_depth];
  logic [elink_frame_pkg::fifo_aw-1:0] wr_ptr;
  logic [elink_frame_pkg::fifo_aw-1:0] rd_ptr;
  logic [elink_frame_pkg::fifo_aw:0]   count;
  logic                                do_push;
  logic                                do_pop;

  assign do_push = push.avail && push.take;
  assign do_pop = pop.avail && pop.take;

  assign push.take = !count[elink_frame_pkg::fifo_aw];  // msb set only when full
  assign pop.avail = |count;
  assign {pop.delim, pop.data} = mem[rd_ptr];           // head word, no read latency

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= {push.delim, push.data};
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;                        // wraps with depth
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== hw/elink_word_if.sv ====
`timescale 1ns/10ps
interface elink_word_if;

  logic [elink_frame_pkg::byte_w-1:0]  data;
  logic [elink_frame_pkg::delim_w-1:0] delim;
  logic                                avail;  // producer holds a word
  logic                                take;   // consumer accepts it

  modport producer (
    output data,
    output delim,
    output avail,
    input  take
  );

  modport consumer (
    input  data,
    input  delim,
    input  avail,
    output take
  );

endinterface

// ==== hw/elink_frame_pkg.sv ====
package elink_frame_pkg;

  localparam int byte_w = 8;
  localparam int delim_w = 2;

  // delimiter sent next to every byte
  localparam logic [delim_w-1:0] delim_data  = 2'b00;
  localparam logic [delim_w-1:0] delim_sop   = 2'b01;
  localparam logic [delim_w-1:0] delim_eop   = 2'b10;
  localparam logic [delim_w-1:0] delim_comma = 2'b11;  // idle, never stored

  localparam int len_w = 10;                          // packet length field

  // word fifos, depth must stay a power of two
  localparam int fifo_depth = 16;
  localparam int fifo_aw = $clog2(fifo_depth);

  // 10 bit symbol moved as 2 bit pairs
  localparam int slots_per_sym = 5;

endpackage

// ==== hw/elink_code_pkg.sv ====
package elink_code_pkg;

  localparam int sym_w = 10;

  localparam logic [7:0] k28_5 = 8'hBC;                 // comma
  localparam logic [7:0] k28_1 = 8'h3C;                 // start of packet
  localparam logic [7:0] k28_6 = 8'hDC;                 // end of packet

  localparam logic [sym_w-1:0] comma_n = 10'b0011111010; // k28.5 sent at rd-
  localparam logic [sym_w-1:0] comma_p = 10'b1100000101; // k28.5 sent at rd+

  // 5b/6b and 3b/4b codes in their rd- form, bit a (or f) is the msb
  localparam logic [5:0] tbl6 [32] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
  };
  localparam logic [3:0] tbl4 [8] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
  };

  function automatic logic [5:0] enc6(input logic [4:0] x, input logic k, input logic rd);
    logic [5:0] c;
    c = k ? 6'b001111 : tbl6[x];                         // only k28 is sent
    if (rd && ($countones(c) != 3 || c == 6'b111000))
      c = ~c;                                            // d.07 has two balanced forms
    return c;
  endfunction

  function automatic logic [3:0] enc4(input logic [2:0] y, input logic k, input logic a7,
                                      input logic rd);
    logic [3:0] c;
    c = (y == 3'd7 && a7) ? 4'b0111 : tbl4[y];
    if (k && $countones(c) == 2 && c != 4'b1100)
      c = ~c;                                            // k.x.1/2/5/6 flip polarity
    if (rd && (k || $countones(c) != 2 || c == 4'b1100))
      c = ~c;
    return c;
  endfunction

  // result is {new rd, symbol}, rd high means positive
  function automatic logic [sym_w:0] encode_8b10b(input logic [7:0] d, input logic k,
                                                  input logic rd);
    logic [5:0] c6;
    logic [3:0] c4;
    logic rd6;
    logic a7;
    c6 = enc6(d[4:0], k, rd);
    rd6 = rd ^ ($countones(c6) != 3);
    a7 = k || (!rd6 && (d[4:0] == 5'd17 || d[4:0] == 5'd18 || d[4:0] == 5'd20)) ||
         (rd6 && (d[4:0] == 5'd11 || d[4:0] == 5'd13 || d[4:0] == 5'd14));  // avoid run of 5
    c4 = enc4(d[7:5], k, a7, rd6);
    return {rd6 ^ ($countones(c4) != 2), c6, c4};
  endfunction

  // result is {k, byte}
  function automatic logic [8:0] decode_8b10b(input logic [sym_w-1:0] s);
    logic [5:0] c6;
    logic [3:0] c4;
    logic k;
    logic rd4;
    logic [4:0] x;
    logic [2:0] y;
    c6 = s[9:4];
    c4 = s[3:0];
    k = (c6 == 6'b001111) || (c6 == 6'b110000);
    rd4 = $countones(c6) > 3;                            // disparity seen by the 4b block
    x = 5'd28;
    y = 3'd0;
    for (int i = 0; i < 32; i++)
    begin
      if (!k && (c6 == enc6(5'(i), 1'b0, 1'b0) || c6 == enc6(5'(i), 1'b0, 1'b1)))
        x = 5'(i);
    end
    for (int j = 0; j < 8; j++)
    begin
      if (k)
      begin
        if (c4 == enc4(3'(j), 1'b1, 1'b1, rd4))
          y = 3'(j);
      end
      else if (c4 == enc4(3'(j), 1'b0, 1'b0, 1'b0) || c4 == enc4(3'(j), 1'b0, 1'b0, 1'b1) ||
               c4 == enc4(3'(j), 1'b0, 1'b1, 1'b0) || c4 == enc4(3'(j), 1'b0, 1'b1, 1'b1))
        y = 3'(j);
    end
    return {k, y, x};
  endfunction

endpackage
